/* Bender.yml */
package:
  name: mem_ctrl

export_include_dirs:
  - rtl

sources:
  - rtl/memBusPkg.sv
  - rtl/memCtrlPkg.sv
  - rtl/memArbFsm.sv
  - rtl/byteStepper.sv
  - rtl/byteAssembler.sv
  - rtl/memCtrl.sv
  - target: test
    files:
      - test/memCtrlChk.sv
      - test/memCtrlTb.sv

/* build.f */
+incdir+rtl
rtl/memBusPkg.sv
rtl/memCtrlPkg.sv
rtl/memArbFsm.sv
rtl/byteStepper.sv
rtl/byteAssembler.sv
rtl/memCtrl.sv
test/memCtrlChk.sv
test/memCtrlTb.sv

/* rtl/byteAssembler.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memCfg_cfg.svh"

module byteAssembler (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   advance,
    input  wire logic                   captureByte,
    input  wire memBusPkg::memLen_t     stage,
    input  wire logic [`MEM_BYTE_W-1:0] ramRdata,
    input  wire logic [`MEM_DATA_W-1:0] storeData,
    output logic [`MEM_DATA_W-1:0]      assembled,
    output logic [`MEM_BYTE_W-1:0]      storeByte
);
    import memBusPkg::*;

    memLen_t lastStage;
    logic    lastRead;

    // The RAM answers every cycle, frozen or not, so these follow the address
    // that was really on the bus one cycle ago. A byte that lands during a
    // freeze is still caught in its lane.
    always_ff @(posedge clk) begin
        if (rst)
            lastRead <= 1'b0;
        else
            lastRead <= captureByte;
    end

    always_ff @(posedge clk) begin
        lastStage <= stage;
    end

    // first read of an access wipes old lanes
    always_ff @(posedge clk) begin
        if (advance && captureByte && stage == '0)
            assembled <= '0;
        if (lastRead)
            assembled[lastStage[1:0]*`MEM_BYTE_W +: `MEM_BYTE_W] <= ramRdata;
    end

    assign storeByte = storeData[stage[1:0]*`MEM_BYTE_W +: `MEM_BYTE_W];

endmodule

`default_nettype wire

/* rtl/byteStepper.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memCfg_cfg.svh"

module byteStepper (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   advance,
    input  wire logic                   stepClear,
    input  wire logic                   stepInc,
    input  wire logic [`MEM_ADDR_W-1:0] baseAddr,
    output memBusPkg::memLen_t          stage,
    output logic [`MEM_ADDR_W-1:0]      ramAddr
);

    // bytes already put on the bus in this access
    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (advance) begin
            if (stepClear)
                stage <= '0;
            else if (stepInc)
                stage <= stage + 1'b1;
        end
    end

    // little endian, lowest byte first
    assign ramAddr = baseAddr + `MEM_ADDR_W'(stage);

endmodule

`default_nettype wire

/* rtl/memArbFsm.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memCfg_cfg.svh"

module memArbFsm (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   ready,
    input  wire logic                   ioFull,
    input  wire memBusPkg::fetchReq_t   fetchReq,
    input  wire memBusPkg::dataReq_t    dataReq,
    input  wire memBusPkg::memLen_t     stage,
    input  wire logic [`MEM_DATA_W-1:0] assembled,
    output logic                        advance,
    output logic                        stepClear,
    output logic                        stepInc,
    output logic                        captureByte,
    output logic                        writeEn,
    output logic [`MEM_ADDR_W-1:0]      baseAddr,
    output logic [`MEM_DATA_W-1:0]      storeData,
    output memBusPkg::fetchRsp_t        fetchRsp,
    output memBusPkg::dataRsp_t         dataRsp,
    output memCtrlPkg::memOwner_e       owner
);
    import memBusPkg::*;
    import memCtrlPkg::*;

    memState_e              state;
    memOp_e                 op;
    memOp_e                 reqOp;
    memLen_t                len;
    logic                   fetchDone;
    logic                   dataDone;
    logic                   accept;
    logic                   ending;
    logic [`MEM_DATA_W-1:0] loadWord;

    assign advance = ready && !ioFull;

    // data cache goes first when both wait
    assign accept = (state == stIdle) && (dataReq.valid || fetchReq.valid);

    always_comb begin
        if (dataReq.valid)
            reqOp = dataReq.store ? opStore : opLoad;
        else
            reqOp = opFetch;
    end

    // last byte moved, done not yet raised
    assign ending = (state != stIdle) && (stage == len) && !fetchDone && !dataDone;

    assign stepClear   = accept;
    assign stepInc     = (state != stIdle) && (stage != len);
    assign captureByte = ((state == stLoad) || (state == stFetch)) && (stage != len);
    // frozen bus reads, never writes
    assign writeEn     = (state == stStore) && (stage != len) && advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stIdle;
            op        <= opLoad;
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else if (advance) begin
            fetchDone <= ending && (op == opFetch);
            dataDone  <= ending && (op != opFetch);
            case (state)
                stIdle: begin
                    if (accept) begin
                        op <= reqOp;
                        case (reqOp)
                            opStore: state <= stStore;
                            opFetch: state <= stFetch;
                            default: state <= stLoad;
                        endcase
                    end
                end
                default: begin
                    if (fetchDone || dataDone)
                        state <= stIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance && accept) begin
            if (dataReq.valid) begin
                baseAddr  <= dataReq.addr;
                storeData <= dataReq.wdata;
                len       <= dataReq.len;
            end else begin
                baseAddr <= fetchReq.addr;
                len      <= memLen_t'(`MEM_MAX_LEN);
            end
        end
    end

    always_comb begin
        case (len)
            3'd1:    loadWord = {{(`MEM_DATA_W - `MEM_BYTE_W){1'b0}},
                                 assembled[`MEM_BYTE_W-1:0]};
            3'd2:    loadWord = {{(`MEM_DATA_W - 2*`MEM_BYTE_W){1'b0}},
                                 assembled[2*`MEM_BYTE_W-1:0]};
            default: loadWord = assembled;
        endcase
    end

    // payload only shows with its done pulse
    assign fetchRsp = '{done: fetchDone, inst: fetchDone ? assembled : '0};
    assign dataRsp  = '{done: dataDone, data: (dataDone && op == opLoad) ? loadWord : '0};

    always_comb begin
        case (state)
            stLoad, stStore: owner = ownData;
            stFetch:         owner = ownFetch;
            default:         owner = ownNone;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/memBusPkg.sv */
`default_nettype none
`include "memCfg_cfg.svh"

package memBusPkg;

    // wide enough to count 0 .. MEM_MAX_LEN
    typedef logic [$clog2(`MEM_MAX_LEN + 1)-1:0] memLen_t;

    typedef struct packed {
        logic                   we;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_BYTE_W-1:0] wdata;
    } ramPort_t;

    typedef struct packed {
        logic                   valid;
        logic [`MEM_ADDR_W-1:0] addr;
    } fetchReq_t;

    typedef struct packed {
        logic                   done;
        logic [`MEM_DATA_W-1:0] inst;
    } fetchRsp_t;

    // len is 1, 2 or 4
    typedef struct packed {
        logic                   valid;
        logic                   store;
        memLen_t                len;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
    } dataReq_t;

    typedef struct packed {
        logic                   done;
        logic [`MEM_DATA_W-1:0] data;
    } dataRsp_t;

endpackage

`default_nettype wire

/* rtl/memCfg_cfg.svh */
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// byte address and word
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// the RAM moves one byte per cycle
`define MEM_BYTE_W 8

// longest access, in bytes
`define MEM_MAX_LEN 4

`endif

/* rtl/memCtrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memCfg_cfg.svh"

module memCtrl (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   ready,
    input  wire logic                   ioFull,
    input  wire memBusPkg::fetchReq_t   fetchReq,
    output memBusPkg::fetchRsp_t        fetchRsp,
    input  wire memBusPkg::dataReq_t    dataReq,
    output memBusPkg::dataRsp_t         dataRsp,
    output memBusPkg::ramPort_t         ramOut,
    input  wire logic [`MEM_BYTE_W-1:0] ramRdata,
    output memCtrlPkg::memOwner_e       owner
);
    import memBusPkg::*;

    logic                   advance;
    logic                   stepClear;
    logic                   stepInc;
    logic                   captureByte;
    logic                   writeEn;
    logic [`MEM_ADDR_W-1:0] baseAddr;
    logic [`MEM_DATA_W-1:0] storeData;
    logic [`MEM_DATA_W-1:0] assembled;
    logic [`MEM_ADDR_W-1:0] ramAddr;
    logic [`MEM_BYTE_W-1:0] storeByte;
    memLen_t                stage;

    memArbFsm u_fsm (
        .clk(clk), .rst(rst), .ready(ready), .ioFull(ioFull),
        .fetchReq(fetchReq), .dataReq(dataReq),
        .stage(stage), .assembled(assembled),
        .advance(advance), .stepClear(stepClear), .stepInc(stepInc),
        .captureByte(captureByte), .writeEn(writeEn),
        .baseAddr(baseAddr), .storeData(storeData),
        .fetchRsp(fetchRsp), .dataRsp(dataRsp), .owner(owner)
    );

    byteStepper u_step (
        .clk(clk), .rst(rst), .advance(advance),
        .stepClear(stepClear), .stepInc(stepInc), .baseAddr(baseAddr),
        .stage(stage), .ramAddr(ramAddr)
    );

    byteAssembler u_asm (
        .clk(clk), .rst(rst), .advance(advance), .captureByte(captureByte),
        .stage(stage), .ramRdata(ramRdata), .storeData(storeData),
        .assembled(assembled), .storeByte(storeByte)
    );

    assign ramOut = '{we: writeEn, addr: ramAddr, wdata: storeByte};

endmodule

`default_nettype wire

/* rtl/memCtrlPkg.sv */
`default_nettype none

package memCtrlPkg;

    typedef enum logic [1:0] {stIdle, stLoad, stStore, stFetch} memState_e;

    typedef enum logic [1:0] {opLoad, opStore, opFetch} memOp_e;

    // wait level seen by both requesters
    typedef enum logic [1:0] {
        ownNone  = 2'b00,
        ownData  = 2'b01,
        ownFetch = 2'b10
    } memOwner_e;

endpackage

`default_nettype wire

/* test/memCtrlChk.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrlChk (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  ready,
    input wire logic                  ioFull,
    input wire memBusPkg::fetchRsp_t  fetchRsp,
    input wire memBusPkg::dataRsp_t   dataRsp,
    input wire memBusPkg::ramPort_t   ramOut,
    input wire memCtrlPkg::memOwner_e owner
);
    import memCtrlPkg::*;

    int failCount = 0;

    // done may only stay high across a frozen edge
    fetchDoneOnce: assert property (@(posedge clk) disable iff (rst)
        fetchRsp.done && ready && !ioFull |=> !fetchRsp.done)
        else begin
            $error("fetch done stayed high after a moving edge");
            failCount++;
        end

    dataDoneOnce: assert property (@(posedge clk) disable iff (rst)
        dataRsp.done && ready && !ioFull |=> !dataRsp.done)
        else begin
            $error("data done stayed high after a moving edge");
            failCount++;
        end

    noFetchWrite: assert property (@(posedge clk) disable iff (rst)
        !(ramOut.we && owner == ownFetch))
        else begin
            $error("RAM write enable high while the fetch owns the bus");
            failCount++;
        end

    // write enable is the one output allowed to drop
    frozenHold: assert property (@(posedge clk) disable iff (rst)
        ioFull |=> $stable(owner) && $stable(fetchRsp) && $stable(dataRsp)
            && $stable(ramOut.addr) && $stable(ramOut.wdata))
        else begin
            $error("controller outputs moved while ioFull was high");
            failCount++;
        end

endmodule

bind memCtrl memCtrlChk u_chk (
    .clk(clk), .rst(rst), .ready(ready), .ioFull(ioFull),
    .fetchRsp(fetchRsp), .dataRsp(dataRsp), .ramOut(ramOut), .owner(owner)
);

`default_nettype wire

/* test/memCtrlTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memCfg_cfg.svh"

module memCtrlTb;
    import memBusPkg::*;
    import memCtrlPkg::*;

    localparam int timeoutCycles = 200;

    logic                   clk;
    logic                   rst;
    logic                   ready;
    logic                   ioFull;
    fetchReq_t              fetchReq;
    fetchRsp_t              fetchRsp;
    dataReq_t               dataReq;
    dataRsp_t               dataRsp;
    ramPort_t               ramOut;
    logic [`MEM_BYTE_W-1:0] ramRdata;
    memOwner_e              owner;
    logic [`MEM_BYTE_W-1:0] ram [256];
    logic [31:0]            seed;
    int                     errCount;

    memCtrl u_dut (
        .clk(clk), .rst(rst), .ready(ready), .ioFull(ioFull),
        .fetchReq(fetchReq), .fetchRsp(fetchRsp), .dataReq(dataReq), .dataRsp(dataRsp),
        .ramOut(ramOut), .ramRdata(ramRdata), .owner(owner)
    );

    always #4 clk = ~clk;

    // byte RAM, read data one cycle after its address
    always @(posedge clk) begin
        if (ramOut.we)
            ram[ramOut.addr[7:0]] <= ramOut.wdata;
        ramRdata <= ram[ramOut.addr[7:0]];
    end

    // lcg step
    function automatic logic [7:0] randByte();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[23:16];
    endfunction

    // n model bytes, little endian, zero above
    function automatic logic [`MEM_DATA_W-1:0] ramWord(input logic [7:0] addr, input int n);
        logic [`MEM_DATA_W-1:0] w;
        int                     i;
        w = '0;
        for (i = 0; i < n; i++)
            w[8*i +: 8] = ram[8'(addr + i)];
        return w;
    endfunction

    task automatic checkWord(input string name, input logic [`MEM_DATA_W-1:0] got, exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkOwner(input string name, input memOwner_e got, exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %s, expected %s", $time, name, got.name(), exp.name());
            errCount++;
        end
    endtask

    task automatic checkRam(input string name, input logic [`MEM_BYTE_W-1:0] got, exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errCount++;
        end
    endtask

    // random freeze for the coming edge
    task automatic driveStall(input bit enable, inout int stalls);
        logic [7:0] r;
        r = randByte();
        ready = !(enable && r < 8'd90 && r[0]);
        ioFull = enable && r < 8'd90 && !r[0];
        stalls += int'(!ready || ioFull);
    endtask

    // one access for one requester, returns the word that comes with done
    task automatic runAccess(input bit isFetch, input bit isStore, input int n,
            input logic [7:0] addr, input logic [`MEM_DATA_W-1:0] wdata, input bit stallOn,
            output logic [`MEM_DATA_W-1:0] rdata);
        int   cycles;
        int   stalls;
        logic done;
        cycles = 0;
        stalls = 0;
        done = 1'b0;
        if (isFetch)
            fetchReq = '{valid: 1'b1, addr: 32'(addr)};
        else
            dataReq = '{valid: 1'b1, store: isStore, len: memLen_t'(n),
                        addr: 32'(addr), wdata: wdata};
        driveStall(stallOn, stalls);
        while (!done && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
            done = isFetch ? fetchRsp.done : dataRsp.done;
            if (!stallOn)
                checkOwner("owner", owner, isFetch ? ownFetch : ownData);
            if (!done)
                driveStall(stallOn, stalls);
        end
        rdata = isFetch ? fetchRsp.inst : dataRsp.data;
        if (isFetch)
            fetchReq.valid = 1'b0;
        else
            dataReq.valid = 1'b0;
        driveStall(1'b0, stalls);
        if (!done) begin
            $display("timeout: no done pulse for the access at address %h", addr);
            errCount++;
        end
        // accept edge, n bytes, one edge to raise done, plus every frozen edge
        checkWord("done latency", 32'(cycles), 32'(n + 2 + stalls));
        @(negedge clk);
        checkOwner("owner after done", owner, ownNone);
    endtask

    task automatic idleAfterReset();
        checkWord("fetchRsp.done", 32'(fetchRsp.done), 32'd0);
        checkWord("dataRsp.done", 32'(dataRsp.done), 32'd0);
        checkWord("ramOut.we", 32'(ramOut.we), 32'd0);
        checkOwner("owner", owner, ownNone);
    endtask

    task automatic readAndCompare(input bit isFetch, input int n, input bit stallOn);
        logic [7:0]             addr;
        logic [`MEM_DATA_W-1:0] got;
        addr = randByte();
        runAccess(isFetch, 1'b0, n, addr, '0, stallOn, got);
        checkWord(isFetch ? "fetchRsp.inst" : "dataRsp.data", got, ramWord(addr, n));
    endtask

    // store, check the bytes around it, then read it back
    task automatic storeAndReadBack(input int n, input bit stallOn);
        logic [7:0]             addr;
        logic [`MEM_DATA_W-1:0] wdata;
        logic [`MEM_DATA_W-1:0] got;
        logic [`MEM_DATA_W-1:0] mask;
        logic [7:0]             expBytes [8];
        int                     i;
        addr = randByte();
        wdata = {randByte(), randByte(), randByte(), randByte()};
        mask = (n == 4) ? '1 : (32'd1 << (8 * n)) - 1;
        for (i = 0; i < 8; i++)
            expBytes[i] = ram[8'(addr + i - 2)];
        for (i = 0; i < n; i++)
            expBytes[i + 2] = wdata[8*i +: 8];
        runAccess(1'b0, 1'b1, n, addr, wdata, stallOn, got);
        for (i = 0; i < 8; i++)
            checkRam($sformatf("ram[%0d]", 8'(addr + i - 2)),
                     ram[8'(addr + i - 2)], expBytes[i]);
        runAccess(1'b0, 1'b0, n, addr, '0, stallOn, got);
        checkWord("dataRsp.data after store", got, wdata & mask);
    endtask

    // both raised on one edge, the owner checks show the load runs first
    task automatic dataBeforeFetch();
        logic [7:0]             fetchAddr;
        logic [`MEM_DATA_W-1:0] got;
        fetchAddr = randByte();
        fetchReq = '{valid: 1'b1, addr: 32'(fetchAddr)};
        readAndCompare(1'b0, `MEM_MAX_LEN, 1'b0);
        runAccess(1'b1, 1'b0, `MEM_MAX_LEN, fetchAddr, '0, 1'b0, got);
        checkWord("fetchRsp.inst", got, ramWord(fetchAddr, `MEM_MAX_LEN));
    endtask

    initial begin
        int lens [3];
        int i;
        lens = '{1, 2, 4};
        clk = 1'b0;
        rst = 1'b1;
        ready = 1'b1;
        ioFull = 1'b0;
        fetchReq = '0;
        dataReq = '0;
        ramRdata = '0;
        seed = 32'd2936;
        errCount = 0;
        for (i = 0; i < 256; i++)
            ram[i] = randByte();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        idleAfterReset();
        readAndCompare(1'b1, `MEM_MAX_LEN, 1'b0);
        for (i = 0; i < 3; i++) begin
            readAndCompare(1'b0, lens[i], 1'b0);
            storeAndReadBack(lens[i], 1'b0);
        end
        dataBeforeFetch();
        // same accesses under random freezes
        for (i = 0; i < 12; i++) begin
            readAndCompare(1'b1, `MEM_MAX_LEN, 1'b1);
            readAndCompare(1'b0, lens[i % 3], 1'b1);
            storeAndReadBack(lens[i % 3], 1'b1);
        end
        $display("memCtrlTb finished with %0d errors and %0d assertion failures",
                 errCount, u_dut.u_chk.failCount);
        if (errCount == 0 && u_dut.u_chk.failCount == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
